// ==== icache_subsystem.f ====
common/icache_pkg.sv
design/icache_array.sv
design/prefetcher.sv
design/miss_tracker.sv
design/icache_subsystem.sv
verification/mem_responder.sv
verification/icache_subsystem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the icache subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir
EXE=icache_subsystem_sim

verilator --binary --timing --assert -Wno-fatal \
    --top-module icache_subsystem_tb \
    --Mdir "$BUILD" \
    -o "$EXE" \
    -f icache_subsystem.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD/$EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
    echo "simulation reported errors"
    exit 1
fi

if ! grep -q "Done: no errors" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi

echo "simulation passed"
exit 0

// ==== verification/icache_subsystem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_subsystem_tb;

    localparam int CACHE_LINES    = 16;
    localparam int MSHR_ENTRIES   = 4;
    localparam int PREFETCH_DEPTH = 2;

    logic             clock;
    logic             reset;
    logic [1:0]       read_valid;
    logic [1:0][31:0] read_addr;
    logic [1:0]       hit;
    logic [1:0][31:0] hit_data;
    logic             mem_req_valid;
    logic [31:0]      mem_req_addr;
    logic             mem_req_accepted;
    logic [3:0]       req_tag;
    logic [63:0]      mem_data;
    logic [3:0]       mem_data_tag;
    logic             stall;
    logic             clear;
    logic             busy;
    int               accept_count;
    int               dup_count;
    logic [31:0]      first_addr;

    integer seed;
    int     error_count;
    int     errors_at_start;
    int     tests_run;
    int     tests_failed;
    string  test_name;

    icache_subsystem #(
        .CACHE_LINES    (CACHE_LINES),
        .MSHR_ENTRIES   (MSHR_ENTRIES),
        .PREFETCH_DEPTH (PREFETCH_DEPTH)
    ) uut (
        .clock            (clock),
        .reset            (reset),
        .read_valid       (read_valid),
        .read_addr        (read_addr),
        .hit              (hit),
        .hit_data         (hit_data),
        .mem_req_valid    (mem_req_valid),
        .mem_req_addr     (mem_req_addr),
        .mem_req_accepted (mem_req_accepted),
        .req_tag          (req_tag),
        .mem_data         (mem_data),
        .mem_data_tag     (mem_data_tag)
    );

    mem_responder #(
        .LATENCY (6)
    ) responder (
        .clock            (clock),
        .reset            (reset),
        .stall            (stall),
        .clear            (clear),
        .mem_req_valid    (mem_req_valid),
        .mem_req_addr     (mem_req_addr),
        .mem_req_accepted (mem_req_accepted),
        .req_tag          (req_tag),
        .mem_data         (mem_data),
        .mem_data_tag     (mem_data_tag),
        .busy             (busy),
        .accept_count     (accept_count),
        .dup_count        (dup_count),
        .first_addr       (first_addr)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Word at byte address A is A with its upper 16 bits inverted
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        return addr ^ 32'hFFFF_0000;
    endfunction

    task automatic expect_equal(input string what, input logic [63:0] expected,
                                input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s (%s): expected %h, actual %h", test_name, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("%s: timed out waiting for %s", test_name, what);
        error_count++;
    endtask

    task automatic drive_reads(input logic [1:0] valid, input logic [31:0] a0,
                               input logic [31:0] a1);
        @(posedge clock);
        read_valid   <= valid;
        read_addr[0] <= a0;
        read_addr[1] <= a1;
    endtask

    task automatic wait_hits(input logic [1:0] mask, input string what);
        int n;
        n = 0;
        @(negedge clock);
        while (((hit & mask) != mask) && n < 200) begin
            @(negedge clock);
            n++;
        end
        if ((hit & mask) != mask) report_timeout(what);
    endtask

    // No request and nothing on its way back for several cycles
    task automatic wait_quiet();
        int quiet;
        int n;
        quiet = 0;
        n = 0;
        while (quiet < 8 && n < 300) begin
            @(negedge clock);
            n++;
            if (mem_req_valid || busy) quiet = 0;
            else quiet++;
        end
        if (quiet < 8) report_timeout("memory traffic to stop");
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
        wait_quiet();
        @(posedge clock);
        clear <= 1'b1;
        @(posedge clock);
        clear <= 1'b0;
    endtask

    task automatic end_test();
        tests_run++;
        if (error_count == errors_at_start) begin
            $display("test %s: passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, error_count - errors_at_start);
        end
    endtask

    task automatic idle_after_reset();
        logic [31:0] a0;
        logic [31:0] a1;
        start_test("reset");
        for (int i = 0; i < 20; i++) begin
            @(negedge clock);
            expect_equal("request while idle", 64'd0, 64'(mem_req_valid));
        end
        a0 = $random(seed);
        a1 = $random(seed);
        drive_reads(2'b11, a0 & 32'hFFFF_FFFC, a1 & 32'hFFFF_FFFC);
        @(negedge clock);
        expect_equal("hit after reset", 64'd0, 64'(hit));
        drive_reads(2'b00, 32'd0, 32'd0);
        end_test();
    endtask

    task automatic cold_miss();
        logic [31:0] a;
        start_test("cold_miss");
        a = $random(seed);
        a = a & 32'hFFFF_FFFC;
        drive_reads(2'b01, a, 32'd0);
        @(negedge clock);
        expect_equal("first read misses", 64'd0, 64'(hit[0]));
        wait_hits(2'b01, "cold miss fill");
        expect_equal("cold miss data", 64'(expected_word(a)), 64'(hit_data[0]));
        drive_reads(2'b00, 32'd0, 32'd0);
        end_test();
    endtask

    task automatic prefetch_next_lines();
        logic [31:0] l;
        start_test("prefetch");
        l = $random(seed);
        l = l & 32'hFFFF_FFF8;
        drive_reads(2'b01, l, 32'd0);
        wait_hits(2'b01, "missed line");
        drive_reads(2'b00, 32'd0, 32'd0);
        wait_quiet();
        // Next lines must already be there
        drive_reads(2'b11, l + 32'd8, l + 32'd20);
        @(negedge clock);
        expect_equal("prefetched lines hit", 64'd3, 64'(hit));
        expect_equal("line L+1 data", 64'(expected_word(l + 32'd8)), 64'(hit_data[0]));
        expect_equal("line L+2 data", 64'(expected_word(l + 32'd20)), 64'(hit_data[1]));
        drive_reads(2'b00, 32'd0, 32'd0);
        expect_equal("request count", 64'(PREFETCH_DEPTH + 1), 64'(accept_count));
        end_test();
    endtask

    task automatic single_request_per_line();
        logic [31:0] a;
        start_test("no_duplicates");
        a = $random(seed);
        a = a & 32'hFFFF_FFF8;
        drive_reads(2'b11, a, a + 32'd4);
        repeat (40) @(posedge clock);
        @(negedge clock);
        expect_equal("both ports hit", 64'd3, 64'(hit));
        expect_equal("slot 0 data", 64'(expected_word(a)), 64'(hit_data[0]));
        expect_equal("slot 1 data", 64'(expected_word(a + 32'd4)), 64'(hit_data[1]));
        expect_equal("repeated lines", 64'd0, 64'(dup_count));
        expect_equal("request count", 64'(PREFETCH_DEPTH + 1), 64'(accept_count));
        drive_reads(2'b00, 32'd0, 32'd0);
        end_test();
    endtask

    task automatic slot_priority_stall();
        logic [31:0] a;
        logic [31:0] b;
        start_test("priority_stall");
        a = $random(seed);
        a = a & 32'hFFFF_FFFC;
        // Far away and on another index
        b = a + 32'h0000_1048;
        drive_reads(2'b11, a, b);
        stall <= 1'b1;
        repeat (10) @(posedge clock);
        @(negedge clock);
        // Slot 0 line waits at the memory port
        expect_equal("pending request", 64'd1, 64'(mem_req_valid));
        expect_equal("pending address", 64'(a & 32'hFFFF_FFF8), 64'(mem_req_addr));
        @(posedge clock);
        stall <= 1'b0;
        wait_hits(2'b11, "both stalled lines");
        expect_equal("first accepted line", 64'(a & 32'hFFFF_FFF8), 64'(first_addr));
        expect_equal("slot 0 data", 64'(expected_word(a)), 64'(hit_data[0]));
        expect_equal("slot 1 data", 64'(expected_word(b)), 64'(hit_data[1]));
        drive_reads(2'b00, 32'd0, 32'd0);
        end_test();
    endtask

    task automatic conflict_eviction();
        logic [31:0] a;
        logic [31:0] b;
        start_test("eviction");
        a = $random(seed);
        a = a & 32'hFFFF_FFFC;
        b = a + 32'(CACHE_LINES * 8);
        drive_reads(2'b01, a, 32'd0);
        wait_hits(2'b01, "line A");
        expect_equal("line A data", 64'(expected_word(a)), 64'(hit_data[0]));
        drive_reads(2'b00, 32'd0, 32'd0);
        wait_quiet();
        drive_reads(2'b01, b, 32'd0);
        wait_hits(2'b01, "conflicting line");
        drive_reads(2'b01, a, 32'd0);
        @(negedge clock);
        expect_equal("line A evicted", 64'd0, 64'(hit[0]));
        wait_hits(2'b01, "line A refill");
        expect_equal("refilled data", 64'(expected_word(a)), 64'(hit_data[0]));
        drive_reads(2'b00, 32'd0, 32'd0);
        end_test();
    endtask

    initial begin
        seed         = 96029;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_name    = "none";
        reset        = 1'b1;
        read_valid   = 2'b00;
        read_addr    = '0;
        stall        = 1'b0;
        clear        = 1'b0;
        repeat (16) @(posedge clock);
        reset <= 1'b0;

        idle_after_reset();
        cold_miss();
        prefetch_next_lines();
        single_request_per_line();
        slot_priority_stall();
        conflict_eviction();

        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Guard against a stuck run
    initial begin
        #1_000_000;
        $display("simulation did not finish within the time limit");
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/mem_responder.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_responder #(
    parameter int LATENCY = 6
) (
    input  wire         clock,
    input  wire         reset,
    input  wire         stall,
    input  wire         clear,
    input  wire         mem_req_valid,
    input  wire  [31:0] mem_req_addr,
    output logic        mem_req_accepted,
    output logic [3:0]  req_tag,
    output logic [63:0] mem_data,
    output logic [3:0]  mem_data_tag,
    output logic        busy,
    output int          accept_count,
    output int          dup_count,
    output logic [31:0] first_addr
);

    logic [3:0]  tag_pipe  [LATENCY];
    logic [31:0] addr_pipe [LATENCY];
    logic [31:0] seen [$];
    logic        take;
    logic        dup;

    assign mem_req_accepted = !stall;
    assign take             = mem_req_valid && mem_req_accepted;
    assign mem_data_tag     = tag_pipe[LATENCY-1];

    // Word at byte address A is A with the upper half inverted
    assign mem_data = {(addr_pipe[LATENCY-1] + 32'd4) ^ 32'hFFFF_0000,
                       addr_pipe[LATENCY-1] ^ 32'hFFFF_0000};

    always_comb begin
        busy = 1'b0;
        for (int i = 0; i < LATENCY; i++) begin
            busy = busy || (tag_pipe[i] != 4'd0);
        end
    end

    // A zero tag marks an empty return stage
    always_ff @(posedge clock) begin
        if (reset) begin
            req_tag <= 4'd1;
            for (int i = 0; i < LATENCY; i++) begin
                tag_pipe[i]  <= 4'd0;
                addr_pipe[i] <= 32'd0;
            end
        end else begin
            for (int i = LATENCY - 1; i > 0; i--) begin
                tag_pipe[i]  <= tag_pipe[i-1];
                addr_pipe[i] <= addr_pipe[i-1];
            end
            tag_pipe[0]  <= take ? req_tag : 4'd0;
            addr_pipe[0] <= mem_req_addr;
            if (take) begin
                req_tag <= (req_tag == 4'd15) ? 4'd1 : req_tag + 4'd1;
            end
        end
    end

    // Per-line bookkeeping of accepted requests
    always @(posedge clock) begin
        if (reset || clear) begin
            accept_count <= 0;
            dup_count    <= 0;
            first_addr   <= 32'd0;
            seen.delete();
        end else if (take) begin
            dup = 1'b0;
            foreach (seen[i]) begin
                if (seen[i] == mem_req_addr) dup = 1'b1;
            end
            if (accept_count == 0) first_addr <= mem_req_addr;
            if (dup) dup_count <= dup_count + 1;
            accept_count <= accept_count + 1;
            seen.push_back(mem_req_addr);
        end
    end

endmodule

`default_nettype wire

// ==== design/icache_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_subsystem #(
    parameter int CACHE_LINES    = 16,
    parameter int MSHR_ENTRIES   = 4,
    parameter int PREFETCH_DEPTH = 2
) (
    input  wire                                             clock,
    input  wire                                             reset,

    // Fetch ports with slot 0 as the older instruction
    input  wire  [1:0]                                      read_valid,
    input  wire  [1:0][icache_pkg::ADDR_WIDTH-1:0]          read_addr,
    output logic [1:0]                                      hit,
    output logic [1:0][icache_pkg::WORD_WIDTH-1:0]          hit_data,

    // Memory
    output logic                                            mem_req_valid,
    output logic [icache_pkg::ADDR_WIDTH-1:0]               mem_req_addr,
    input  wire                                             mem_req_accepted,
    input  wire  [icache_pkg::TAG_WIDTH-1:0]                req_tag,
    input  wire  [icache_pkg::LINE_WIDTH-1:0]               mem_data,
    input  wire  [icache_pkg::TAG_WIDTH-1:0]                mem_data_tag
);

    logic [icache_pkg::ADDR_WIDTH-1:0] snoop_addr;
    logic                              in_cache;
    logic                              in_flight;
    logic                              full;
    logic                              fill_valid;
    logic [icache_pkg::ADDR_WIDTH-1:0] fill_addr;

    prefetcher #(
        .PREFETCH_DEPTH (PREFETCH_DEPTH)
    ) prefetcher_inst (
        .clock            (clock),
        .reset            (reset),
        .read_valid       (read_valid),
        .hit              (hit),
        .read_addr        (read_addr),
        .in_cache         (in_cache),
        .in_flight        (in_flight),
        .full             (full),
        .mem_req_accepted (mem_req_accepted),
        .snoop_addr       (snoop_addr),
        .mem_req_valid    (mem_req_valid),
        .mem_req_addr     (mem_req_addr)
    );

    miss_tracker #(
        .MSHR_ENTRIES (MSHR_ENTRIES)
    ) miss_tracker_inst (
        .clock            (clock),
        .reset            (reset),
        .snoop_addr       (snoop_addr),
        .mem_req_valid    (mem_req_valid),
        .mem_req_accepted (mem_req_accepted),
        .req_tag          (req_tag),
        .mem_data_tag     (mem_data_tag),
        .in_flight        (in_flight),
        .full             (full),
        .fill_valid       (fill_valid),
        .fill_addr        (fill_addr)
    );

    // Returned data goes straight into the array
    icache_array #(
        .CACHE_LINES (CACHE_LINES)
    ) icache_array_inst (
        .clock      (clock),
        .reset      (reset),
        .read_valid (read_valid),
        .read_addr  (read_addr),
        .snoop_addr (snoop_addr),
        .fill_valid (fill_valid),
        .fill_addr  (fill_addr),
        .fill_data  (mem_data),
        .hit        (hit),
        .hit_data   (hit_data),
        .in_cache   (in_cache)
    );

endmodule

`default_nettype wire

// ==== design/miss_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module miss_tracker #(
    parameter int MSHR_ENTRIES = 4
) (
    input  wire                                  clock,
    input  wire                                  reset,

    input  wire  [icache_pkg::ADDR_WIDTH-1:0]    snoop_addr,
    output logic                                 in_flight,
    output logic                                 full,

    input  wire                                  mem_req_valid,
    input  wire                                  mem_req_accepted,
    input  wire  [icache_pkg::TAG_WIDTH-1:0]     req_tag,

    input  wire  [icache_pkg::TAG_WIDTH-1:0]     mem_data_tag,
    output logic                                 fill_valid,
    output logic [icache_pkg::ADDR_WIDTH-1:0]    fill_addr
);

    localparam int LB    = icache_pkg::LINE_BITS;
    localparam int IDX_W = (MSHR_ENTRIES > 1) ? $clog2(MSHR_ENTRIES) : 1;

    logic [MSHR_ENTRIES-1:0]         ent_valid;
    logic [icache_pkg::TAG_WIDTH-1:0] ent_tag  [MSHR_ENTRIES];
    logic [LB-1:0]                   ent_line [MSHR_ENTRIES];

    logic                    alloc;
    logic [IDX_W-1:0]        alloc_idx;
    logic [MSHR_ENTRIES-1:0] snoop_match;
    logic [MSHR_ENTRIES-1:0] ret_match;
    logic [LB-1:0]           ret_line;
    logic [LB-1:0]           snoop_line;

    assign alloc      = mem_req_valid && mem_req_accepted;
    assign snoop_line = snoop_addr[icache_pkg::ADDR_WIDTH-1:icache_pkg::OFFSET_BITS];

    // Scan from the top so the lowest free entry wins
    always_comb begin
        alloc_idx = '0;
        for (int i = MSHR_ENTRIES - 1; i >= 0; i--) begin
            if (!ent_valid[i]) begin
                alloc_idx = IDX_W'(i);
            end
        end
    end

    always_comb begin
        ret_line = '0;
        for (int i = 0; i < MSHR_ENTRIES; i++) begin
            snoop_match[i] = ent_valid[i] && (ent_line[i] == snoop_line);
            ret_match[i]   = ent_valid[i] && (mem_data_tag != '0)
                             && (ent_tag[i] == mem_data_tag);
            if (ret_match[i]) begin
                ret_line = ent_line[i];
            end
        end
    end

    assign in_flight  = |snoop_match;
    assign full       = &ent_valid;
    assign fill_valid = |ret_match;
    assign fill_addr  = {ret_line, {icache_pkg::OFFSET_BITS{1'b0}}};

    // An entry being freed is never the one being allocated
    always_ff @(posedge clock) begin
        if (reset) begin
            ent_valid <= '0;
        end else begin
            for (int i = 0; i < MSHR_ENTRIES; i++) begin
                if (ret_match[i]) begin
                    ent_valid[i] <= 1'b0;
                end
            end
            if (alloc) begin
                ent_valid[alloc_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (alloc) begin
            ent_tag[alloc_idx]  <= req_tag;
            ent_line[alloc_idx] <= snoop_line;
        end
    end

    // Prefetcher must hold off while the table has no room
    no_alloc_when_full_a: assert property (
        @(posedge clock) disable iff (reset)
        alloc |-> !full
    ) else $error("allocation while miss table full");

    // Memory hands out each outstanding tag once
    unique_return_a: assert property (
        @(posedge clock) disable iff (reset)
        $onehot0(ret_match)
    ) else $error("returned tag matches several entries");

endmodule

`default_nettype wire

// ==== design/prefetcher.sv ====
`timescale 1ns/1ps
`default_nettype none

module prefetcher #(
    parameter int PREFETCH_DEPTH = 2
) (
    input  wire                                      clock,
    input  wire                                      reset,

    input  wire  [1:0]                               read_valid,
    input  wire  [1:0]                               hit,
    input  wire  [1:0][icache_pkg::ADDR_WIDTH-1:0]   read_addr,

    input  wire                                      in_cache,
    input  wire                                      in_flight,
    input  wire                                      full,
    input  wire                                      mem_req_accepted,

    output logic [icache_pkg::ADDR_WIDTH-1:0]        snoop_addr,
    output logic                                     mem_req_valid,
    output logic [icache_pkg::ADDR_WIDTH-1:0]        mem_req_addr
);

    localparam int LB    = icache_pkg::LINE_BITS;
    localparam int CNT_W = (PREFETCH_DEPTH > 0) ? $clog2(PREFETCH_DEPTH + 1) : 1;

    icache_pkg::prefetch_state_t state;

    logic [LB-1:0]    ptr;
    logic [LB-1:0]    base;
    logic [CNT_W-1:0] remaining;

    logic          miss_valid;
    logic [LB-1:0] miss_line;
    logic          in_window;
    logic          reload;
    logic          found;
    logic          step;

    // Oldest miss with slot 0 first
    always_comb begin
        miss_valid = 1'b0;
        miss_line  = '0;
        if (read_valid[0] && !hit[0]) begin
            miss_valid = 1'b1;
            miss_line  = read_addr[0][icache_pkg::ADDR_WIDTH-1:icache_pkg::OFFSET_BITS];
        end else if (read_valid[1] && !hit[1]) begin
            miss_valid = 1'b1;
            miss_line  = read_addr[1][icache_pkg::ADDR_WIDTH-1:icache_pkg::OFFSET_BITS];
        end
    end

    // Window covers the miss line and the PREFETCH_DEPTH lines after it
    assign in_window = (miss_line - base) <= LB'(PREFETCH_DEPTH);
    assign reload    = miss_valid && ((state == icache_pkg::PF_IDLE) || !in_window);

    assign found         = in_cache || in_flight;
    assign mem_req_valid = (state == icache_pkg::PF_WALK) && !found && !full;
    assign step          = (state == icache_pkg::PF_WALK)
                           && (found || (mem_req_valid && mem_req_accepted));

    assign snoop_addr   = {ptr, {icache_pkg::OFFSET_BITS{1'b0}}};
    assign mem_req_addr = snoop_addr;

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= icache_pkg::PF_IDLE;
            ptr       <= '0;
            base      <= '0;
            remaining <= '0;
        end else if (reload) begin
            state     <= icache_pkg::PF_WALK;
            ptr       <= miss_line;
            base      <= miss_line;
            remaining <= CNT_W'(PREFETCH_DEPTH);
        end else if (step) begin
            if (remaining == '0) begin
                state <= icache_pkg::PF_IDLE;
            end else begin
                ptr       <= ptr + 1'b1;
                remaining <= remaining - 1'b1;
            end
        end
    end

    // A pending request keeps its line until memory takes it or a new miss redirects the walk
    req_held_a: assert property (
        @(posedge clock) disable iff (reset)
        mem_req_valid && !mem_req_accepted && !reload
        |=> mem_req_valid && (mem_req_addr == $past(mem_req_addr))
    ) else $error("pending request dropped or changed address");

endmodule

`default_nettype wire

// ==== design/icache_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_array #(
    parameter int CACHE_LINES = 16
) (
    input  wire                                      clock,
    input  wire                                      reset,

    input  wire  [1:0]                               read_valid,
    input  wire  [1:0][icache_pkg::ADDR_WIDTH-1:0]   read_addr,
    output logic [1:0]                               hit,
    output logic [1:0][icache_pkg::WORD_WIDTH-1:0]   hit_data,

    input  wire  [icache_pkg::ADDR_WIDTH-1:0]        snoop_addr,
    output logic                                     in_cache,

    input  wire                                      fill_valid,
    input  wire  [icache_pkg::ADDR_WIDTH-1:0]        fill_addr,
    input  wire  [icache_pkg::LINE_WIDTH-1:0]        fill_data
);

    localparam int IDX_BITS = $clog2(CACHE_LINES);
    localparam int IDX_LSB  = icache_pkg::OFFSET_BITS;
    localparam int TAG_LSB  = IDX_LSB + IDX_BITS;
    localparam int TAG_BITS = icache_pkg::ADDR_WIDTH - TAG_LSB;
    localparam int WW       = icache_pkg::WORD_WIDTH;

    logic [CACHE_LINES-1:0]            line_valid;
    logic [TAG_BITS-1:0]               line_tag  [CACHE_LINES];
    logic [icache_pkg::LINE_WIDTH-1:0] line_data [CACHE_LINES];

    logic [IDX_BITS-1:0]               rd_idx [2];
    logic [TAG_BITS-1:0]               rd_tag [2];
    logic [icache_pkg::LINE_WIDTH-1:0] rd_line [2];

    logic [IDX_BITS-1:0] snoop_idx;
    logic [TAG_BITS-1:0] snoop_tag;
    logic [IDX_BITS-1:0] fill_idx;
    logic [TAG_BITS-1:0] fill_tag;

    // Two fetch read ports
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            rd_idx[p]  = read_addr[p][TAG_LSB-1:IDX_LSB];
            rd_tag[p]  = read_addr[p][icache_pkg::ADDR_WIDTH-1:TAG_LSB];
            rd_line[p] = line_data[rd_idx[p]];
            hit[p]     = read_valid[p] && line_valid[rd_idx[p]]
                         && (line_tag[rd_idx[p]] == rd_tag[p]);
            // Lower word sits at the lower address
            if (read_addr[p][icache_pkg::WORD_SEL_BIT]) begin
                hit_data[p] = rd_line[p][2*WW-1:WW];
            end else begin
                hit_data[p] = rd_line[p][WW-1:0];
            end
        end
    end

    // Same tag check for the line the prefetcher is looking at
    assign snoop_idx = snoop_addr[TAG_LSB-1:IDX_LSB];
    assign snoop_tag = snoop_addr[icache_pkg::ADDR_WIDTH-1:TAG_LSB];
    assign in_cache  = line_valid[snoop_idx] && (line_tag[snoop_idx] == snoop_tag);

    assign fill_idx = fill_addr[TAG_LSB-1:IDX_LSB];
    assign fill_tag = fill_addr[icache_pkg::ADDR_WIDTH-1:TAG_LSB];

    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
        end else if (fill_valid) begin
            line_valid[fill_idx] <= 1'b1;
        end
    end

    // A fill replaces whatever line held this index
    always_ff @(posedge clock) begin
        if (fill_valid) begin
            line_tag[fill_idx]  <= fill_tag;
            line_data[fill_idx] <= fill_data;
        end
    end

    // Fill address comes from the miss table and must name a whole line
    fill_aligned_a: assert property (
        @(posedge clock) disable iff (reset)
        fill_valid |-> (fill_addr[icache_pkg::OFFSET_BITS-1:0] == '0)
    ) else $error("fill address not line aligned");

endmodule

`default_nettype wire

// ==== common/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

    // Address and line geometry
    localparam int ADDR_WIDTH  = 32;
    localparam int LINE_BYTES  = 8;
    localparam int OFFSET_BITS = $clog2(LINE_BYTES);
    localparam int LINE_WIDTH  = 64;
    localparam int WORD_WIDTH  = 32;

    // Tag zero means no tag
    localparam int TAG_WIDTH = 4;

    // Line number is the address without its byte offset
    localparam int LINE_BITS = ADDR_WIDTH - OFFSET_BITS;

    // Picks the instruction word inside a line
    localparam int WORD_SEL_BIT = 2;

    // Word at byte address A is A with the upper half inverted
    localparam logic [WORD_WIDTH-1:0] RULE_INVERT_MASK = 32'hFFFF_0000;
    localparam int                    RULE_INVERT_LSB  = 16;

    typedef enum logic {
        PF_IDLE,
        PF_WALK
    } prefetch_state_t;

endpackage

`default_nettype wire
